//--- rtl/l2_hit_resolve.sv
`timescale 1ns/10ps
`default_nettype none

module l2_hit_resolve (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         s1_valid,
    input  l2_tag_pkg::l2_req_t          s1_req,
    input  logic [l2_tag_pkg::WAYS-1:0]  hit_vec,
    input  logic [l2_tag_pkg::WAYS-1:0]  valid_vec,
    output logic [l2_tag_pkg::WAYS-1:0]  way_we,
    output logic [l2_tag_pkg::WAYS-1:0]  way_unvalid,
    output logic [l2_tag_pkg::TAG_W-1:0] wr_tag,
    output logic                         rsp_valid,
    output l2_tag_pkg::l2_rsp_t          rsp
);

    import l2_tag_pkg::*;

    localparam int SETS = 1 << SET_W;

    logic [WAY_W-1:0] rr_ptr [SETS];
    logic             any_hit;
    logic [WAY_W-1:0] hit_way;
    logic [WAY_W-1:0] free_way;
    logic             all_valid;
    logic [WAY_W-1:0] victim;
    logic             fill_miss;

    //////////////////////////////
    // Hit and victim encoding
    //////////////////////////////

    // Lowest matching way
    always_comb begin
        any_hit = 1'b0;
        hit_way = '0;
        for (int i = WAYS - 1; i >= 0; i--) begin
            if (hit_vec[i]) begin
                any_hit = 1'b1;
                hit_way = WAY_W'(i);
            end
        end
    end

    // Lowest invalid way
    always_comb begin
        free_way = '0;
        for (int i = WAYS - 1; i >= 0; i--) begin
            if (!valid_vec[i]) begin
                free_way = WAY_W'(i);
            end
        end
    end

    assign all_valid = &valid_vec;
    assign victim    = all_valid ? rr_ptr[s1_req.set] : free_way;
    assign fill_miss = s1_valid && (s1_req.op == OP_FILL) && !any_hit;

    // Array writes take effect on the stage 1 edge
    assign way_we      = fill_miss ? (WAYS'(1) << victim) : '0;
    assign way_unvalid = (s1_valid && (s1_req.op == OP_INVAL)) ? hit_vec : '0;
    assign wr_tag      = s1_req.tag;

    // Round-robin only advances when a valid line gets replaced
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < SETS; i++) begin
                rr_ptr[i] <= '0;
            end
        end else if (fill_miss && all_valid) begin
            rr_ptr[s1_req.set] <= rr_ptr[s1_req.set] + 1'b1;
        end
    end

    //////////////////////////////
    // Response register
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            rsp.op    <= s1_req.op;
            rsp.set   <= s1_req.set;
            rsp.tag   <= s1_req.tag;
            rsp.hit   <= any_hit;
            rsp.way   <= fill_miss ? victim : hit_way;
            rsp.evict <= fill_miss && all_valid;
        end
    end

endmodule

`default_nettype wire

//--- rtl/l2_tag_pkg.sv
`default_nettype none

package l2_tag_pkg;

    //////////////////////////////
    // Geometry
    //////////////////////////////

    localparam int TAG_W = 25;
    localparam int SET_W = 4;
    localparam int WAYS  = 4;
    localparam int WAY_W = 2;

    //////////////////////////////
    // Command and response types
    //////////////////////////////

    typedef enum logic [1:0] {
        OP_LOOKUP = 2'd0,
        OP_FILL   = 2'd1,
        OP_INVAL  = 2'd2
    } l2_op_e;

    typedef struct packed {
        l2_op_e             op;
        logic [SET_W-1:0]   set;
        logic [TAG_W-1:0]   tag;
    } l2_req_t;

    // Way holds the hit way, or the way written by a fill
    typedef struct packed {
        l2_op_e             op;
        logic [SET_W-1:0]   set;
        logic [TAG_W-1:0]   tag;
        logic               hit;
        logic [WAY_W-1:0]   way;
        logic               evict;
    } l2_rsp_t;

endpackage

`default_nettype wire

//--- rtl/l2_tag_req_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module l2_tag_req_ctrl (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         req_valid,
    input  l2_tag_pkg::l2_req_t          req,
    output logic                         busy,
    output logic [l2_tag_pkg::SET_W-1:0] rd_set,
    output logic [l2_tag_pkg::SET_W-1:0] wr_set,
    output logic [l2_tag_pkg::TAG_W-1:0] cmp_tag,
    output logic                         init_en,
    output logic [l2_tag_pkg::WAY_W-1:0] init_way,
    output logic                         s1_valid,
    output l2_tag_pkg::l2_req_t          s1_req
);

    import l2_tag_pkg::*;

    localparam int SWEEP_W = SET_W + WAY_W;

    logic [SWEEP_W-1:0] sweep_cnt;
    logic               accept;

    //////////////////////////////
    // Reset sweep
    //////////////////////////////

    // Low bits pick the way, high bits the set
    always_ff @(posedge clk) begin
        if (reset) begin
            sweep_cnt <= '0;
            busy      <= 1'b1;
        end else if (busy) begin
            sweep_cnt <= sweep_cnt + 1'b1;
            if (&sweep_cnt) begin
                busy <= 1'b0;
            end
        end
    end

    assign init_en  = busy;
    assign init_way = sweep_cnt[WAY_W-1:0];

    //////////////////////////////
    // Stage 1 request register
    //////////////////////////////

    // Commands during the sweep are dropped
    assign accept = req_valid && !busy;

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            s1_req <= req;
        end
    end

    // Stage 0 read address comes straight from the request
    assign rd_set  = req.set;
    assign wr_set  = busy ? sweep_cnt[SWEEP_W-1:WAY_W] : s1_req.set;
    assign cmp_tag = s1_req.tag;

endmodule

`default_nettype wire

//--- rtl/l2_tag_top.sv
`timescale 1ns/10ps
`default_nettype none

module l2_tag_top (
    input  logic                clk,
    input  logic                reset,
    input  logic                req_valid,
    input  l2_tag_pkg::l2_req_t req,
    output logic                busy,
    output logic                rsp_valid,
    output l2_tag_pkg::l2_rsp_t rsp
);

    import l2_tag_pkg::*;

    logic [SET_W-1:0] rd_set;
    logic [SET_W-1:0] wr_set;
    logic [TAG_W-1:0] cmp_tag;
    logic             init_en;
    logic [WAY_W-1:0] init_way;
    logic             s1_valid;
    l2_req_t          s1_req;
    logic [WAYS-1:0]  hit_vec;
    logic [WAYS-1:0]  valid_vec;
    logic [WAYS-1:0]  way_we;
    logic [WAYS-1:0]  way_unvalid;
    logic [TAG_W-1:0] wr_tag;

    l2_tag_req_ctrl u_req_ctrl (
        .clk       (clk),
        .reset     (reset),
        .req_valid (req_valid),
        .req       (req),
        .busy      (busy),
        .rd_set    (rd_set),
        .wr_set    (wr_set),
        .cmp_tag   (cmp_tag),
        .init_en   (init_en),
        .init_way  (init_way),
        .s1_valid  (s1_valid),
        .s1_req    (s1_req)
    );

    // Raw tag readout stays internal to the array
    l2_tagv_array u_tagv_array (
        .clk         (clk),
        .reset       (reset),
        .rd_set      (rd_set),
        .wr_set      (wr_set),
        .cmp_tag     (cmp_tag),
        .wr_tag      (wr_tag),
        .way_we      (way_we),
        .way_unvalid (way_unvalid),
        .init_en     (init_en),
        .init_way    (init_way),
        .way_tags    (),
        .hit_vec     (hit_vec),
        .valid_vec   (valid_vec)
    );

    l2_hit_resolve u_hit_resolve (
        .clk         (clk),
        .reset       (reset),
        .s1_valid    (s1_valid),
        .s1_req      (s1_req),
        .hit_vec     (hit_vec),
        .valid_vec   (valid_vec),
        .way_we      (way_we),
        .way_unvalid (way_unvalid),
        .wr_tag      (wr_tag),
        .rsp_valid   (rsp_valid),
        .rsp         (rsp)
    );

endmodule

`default_nettype wire

//--- rtl/l2_tagv_array.sv
`timescale 1ns/10ps
`default_nettype none

module l2_tagv_array (
    input  logic                                         clk,
    input  logic                                         reset,
    input  logic [l2_tag_pkg::SET_W-1:0]                 rd_set,
    input  logic [l2_tag_pkg::SET_W-1:0]                 wr_set,
    input  logic [l2_tag_pkg::TAG_W-1:0]                 cmp_tag,
    input  logic [l2_tag_pkg::TAG_W-1:0]                 wr_tag,
    input  logic [l2_tag_pkg::WAYS-1:0]                  way_we,
    input  logic [l2_tag_pkg::WAYS-1:0]                  way_unvalid,
    input  logic                                         init_en,
    input  logic [l2_tag_pkg::WAY_W-1:0]                 init_way,
    output logic [l2_tag_pkg::WAYS-1:0][l2_tag_pkg::TAG_W-1:0] way_tags,
    output logic [l2_tag_pkg::WAYS-1:0]                  hit_vec,
    output logic [l2_tag_pkg::WAYS-1:0]                  valid_vec
);

    import l2_tag_pkg::*;

    localparam int SETS = 1 << SET_W;

    logic [SETS-1:0]  valid_bits [WAYS];
    logic [WAYS-1:0]  bram_we;
    logic [TAG_W-1:0] bram_din;

    //////////////////////////////
    // Write port steering
    //////////////////////////////

    // During init only the swept way is written, with zeros
    always_comb begin
        for (int i = 0; i < WAYS; i++) begin
            bram_we[i] = init_en ? (init_way == WAY_W'(i)) : way_we[i];
        end
    end

    assign bram_din = init_en ? '0 : wr_tag;

    // Valid bits per way, unvalid wins over a write
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < WAYS; i++) begin
                valid_bits[i] <= '0;
            end
        end else if (init_en) begin
            valid_bits[init_way][wr_set] <= 1'b0;
        end else begin
            for (int i = 0; i < WAYS; i++) begin
                if (way_unvalid[i]) begin
                    valid_bits[i][wr_set] <= 1'b0;
                end else if (way_we[i]) begin
                    valid_bits[i][wr_set] <= 1'b1;
                end
            end
        end
    end

    //////////////////////////////
    // Tag ways
    //////////////////////////////

    tag_bram #(.DATA_WIDTH(TAG_W), .ADDR_WIDTH(SET_W)) u_way0 (
        .clk   (clk),
        .we    (bram_we[0]),
        .waddr (wr_set),
        .din   (bram_din),
        .raddr (rd_set),
        .dout  (way_tags[0])
    );

    tag_bram #(.DATA_WIDTH(TAG_W), .ADDR_WIDTH(SET_W)) u_way1 (
        .clk   (clk),
        .we    (bram_we[1]),
        .waddr (wr_set),
        .din   (bram_din),
        .raddr (rd_set),
        .dout  (way_tags[1])
    );

    tag_bram #(.DATA_WIDTH(TAG_W), .ADDR_WIDTH(SET_W)) u_way2 (
        .clk   (clk),
        .we    (bram_we[2]),
        .waddr (wr_set),
        .din   (bram_din),
        .raddr (rd_set),
        .dout  (way_tags[2])
    );

    tag_bram #(.DATA_WIDTH(TAG_W), .ADDR_WIDTH(SET_W)) u_way3 (
        .clk   (clk),
        .we    (bram_we[3]),
        .waddr (wr_set),
        .din   (bram_din),
        .raddr (rd_set),
        .dout  (way_tags[3])
    );

    // Compare against the stage-1 set, tags arrive one cycle after rd_set
    always_comb begin
        for (int i = 0; i < WAYS; i++) begin
            valid_vec[i] = valid_bits[i][wr_set];
            hit_vec[i]   = valid_vec[i] && (way_tags[i] == cmp_tag);
        end
    end

endmodule

`default_nettype wire

//--- rtl/tag_bram.sv
`timescale 1ns/10ps
`default_nettype none

module tag_bram #(
    parameter int DATA_WIDTH = 25,
    parameter int ADDR_WIDTH = 4
) (
    input  logic                  clk,
    input  logic                  we,
    input  logic [ADDR_WIDTH-1:0] waddr,
    input  logic [DATA_WIDTH-1:0] din,
    input  logic [ADDR_WIDTH-1:0] raddr,
    output logic [DATA_WIDTH-1:0] dout
);

    localparam int DEPTH = 1 << ADDR_WIDTH;

    logic [DATA_WIDTH-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= din;
        end
    end

    // Write-first read port
    // Same-address write in this cycle is forwarded to the output
    always_ff @(posedge clk) begin
        if (we && (waddr == raddr)) begin
            dout <= din;
        end else begin
            dout <= mem[raddr];
        end
    end

endmodule

`default_nettype wire

//--- sources.f
rtl/l2_tag_pkg.sv
rtl/tag_bram.sv
rtl/l2_tagv_array.sv
rtl/l2_tag_req_ctrl.sv
rtl/l2_hit_resolve.sv
rtl/l2_tag_top.sv
verif/l2_tag_tb.sv

//--- verif/l2_tag_patterns.txt
// op set tag hit way evict gap  (op 0 lookup, 1 fill, 2 invalidate)
// gap 1 waits for idle first, gap 0 issues on the cycle after the previous command
0 0 0000123 0 0 0 1
0 f 1ffffff 0 0 0 1
1 3 0000a01 0 0 0 1
1 3 0000a02 0 1 0 1
1 3 0000a03 0 2 0 1
1 3 0000a04 0 3 0 1
0 3 0000a01 1 0 0 1
0 3 0000a02 1 1 0 1
0 3 0000a03 1 2 0 1
0 3 0000a04 1 3 0 1
1 3 0000a03 1 2 0 1
0 3 0000a01 1 0 0 1
1 3 0000a05 0 0 1 1
1 3 0000a06 0 1 1 1
0 3 0000a01 0 0 0 1
0 3 0000a02 0 0 0 1
0 3 0000a05 1 0 0 1
0 3 0000a06 1 1 0 1
2 3 0000a03 1 2 0 1
0 3 0000a03 0 0 0 1
1 3 0000a07 0 2 0 1
0 3 0000a07 1 2 0 1
2 3 0000bad 0 0 0 1
1 5 0000c01 0 0 0 1
0 5 0000c01 1 0 0 0
1 5 0000c02 0 1 0 1
1 5 0000c03 0 2 0 0
0 5 0000c03 1 2 0 0

//--- verif/l2_tag_tb.sv
`timescale 1ns/10ps
`default_nettype none

module l2_tag_tb;

    import l2_tag_pkg::*;

    localparam int PAT_MAX = 64;
    localparam int FIELDS  = 7;

    logic    clk;
    logic    reset;
    logic    req_valid;
    l2_req_t req;
    logic    busy;
    logic    rsp_valid;
    l2_rsp_t rsp;

    logic [31:0] pat_mem [PAT_MAX*FIELDS];
    l2_rsp_t     exp_q [$];
    int          issue_q [$];
    int          cycle_cnt = 0;
    int          error_count = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    integer      seed;

    // Reference copy of the one set used by the random fills
    logic [TAG_W-1:0] m_tag [WAYS];
    logic [WAYS-1:0]  m_valid;
    logic [WAY_W-1:0] m_rr;

    l2_tag_top u_l2_tag_top (
        .clk       (clk),
        .reset     (reset),
        .req_valid (req_valid),
        .req       (req),
        .busy      (busy),
        .rsp_valid (rsp_valid),
        .rsp       (rsp)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    //////////////////////////////
    // Helpers
    //////////////////////////////

    task automatic check(input string name, input logic [63:0] actual,
                         input logic [63:0] expected);
        if (actual !== expected) begin
            $display("ERROR at %0t ns: %s is 0x%0h, expected 0x%0h",
                     $time, name, actual, expected);
            error_count++;
        end
    endtask

    function automatic string op_text(input l2_op_e op);
        case (op)
            OP_FILL:  return "fill";
            OP_INVAL: return "invalidate";
            default:  return "lookup";
        endcase
    endfunction

    // Driven on a falling edge and sampled on the next rising edge
    task automatic issue(input l2_rsp_t exp);
        req_valid = 1'b1;
        req.op    = exp.op;
        req.set   = exp.set;
        req.tag   = exp.tag;
        exp_q.push_back(exp);
        issue_q.push_back(cycle_cnt);
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < 10) begin
            @(negedge clk);
            n++;
        end
        if (exp_q.size() != 0) begin
            $display("No response within 10 cycles at %0t ns", $time);
            error_count++;
            exp_q.delete();
            issue_q.delete();
        end
    endtask

    // Victim rule applied to the reference set
    task automatic predict(input l2_op_e op, input logic [SET_W-1:0] set,
                           input logic [TAG_W-1:0] tag, output l2_rsp_t exp);
        int victim;
        exp     = '0;
        exp.op  = op;
        exp.set = set;
        exp.tag = tag;
        victim  = -1;
        for (int w = WAYS - 1; w >= 0; w--) begin
            if (m_valid[w] && m_tag[w] == tag) begin
                exp.hit = 1'b1;
                exp.way = WAY_W'(w);
            end
            if (!m_valid[w]) begin
                victim = w;
            end
        end
        if (op == OP_FILL && !exp.hit) begin
            if (victim < 0) begin
                exp.way   = m_rr;
                exp.evict = 1'b1;
                m_rr      = m_rr + 1'b1;
            end else begin
                exp.way = WAY_W'(victim);
            end
            m_tag[exp.way]   = tag;
            m_valid[exp.way] = 1'b1;
        end else if (op == OP_INVAL && exp.hit) begin
            m_valid[exp.way] = 1'b0;
        end
    endtask

    //////////////////////////////
    // Response checking
    //////////////////////////////

    always @(negedge clk) begin : rsp_monitor
        l2_rsp_t exp;
        int      errs_before;
        if (!reset && rsp_valid) begin
            if (exp_q.size() == 0) begin
                $display("A response arrived at %0t ns with no command outstanding", $time);
                error_count++;
            end else begin
                exp = exp_q.pop_front();
                errs_before = error_count;
                check("rsp latency", cycle_cnt - issue_q.pop_front(), 2);
                check("rsp.op", rsp.op, exp.op);
                check("rsp.set", rsp.set, exp.set);
                check("rsp.tag", rsp.tag, exp.tag);
                check("rsp.hit", rsp.hit, exp.hit);
                check("rsp.evict", rsp.evict, exp.evict);
                // Way means nothing on a lookup or invalidate miss
                if (exp.hit || exp.op == OP_FILL) begin
                    check("rsp.way", rsp.way, exp.way);
                end
                tests_run++;
                if (error_count != errs_before) begin
                    tests_failed++;
                end
                $display("Test %0d: %s set %h tag %h %s", tests_run, op_text(exp.op),
                         exp.set, exp.tag, (error_count == errs_before) ? "ok" : "FAILED");
            end
        end
    end

    //////////////////////////////
    // Tests
    //////////////////////////////

    task automatic sweep_test();
        int n;
        int errs_before;
        bit early_rsp;
        errs_before = error_count;
        n = 0;
        early_rsp = 1'b0;
        check("busy", busy, 1);
        check("rsp_valid", rsp_valid, 0);
        req.op  = OP_LOOKUP;
        req.set = 4'h2;
        req.tag = 25'h155;
        while (busy && n < 80) begin
            req_valid = (n == 10);
            @(negedge clk);
            n++;
            early_rsp = early_rsp | rsp_valid;
        end
        req_valid = 1'b0;
        if (busy) begin
            $display("busy did not fall within 80 cycles after reset");
            error_count++;
        end else begin
            check("busy fall cycle", n, 64);
        end
        if (early_rsp) begin
            $display("A command issued during the reset sweep got a response");
            error_count++;
        end
        tests_run++;
        if (error_count != errs_before) begin
            tests_failed++;
        end
        $display("Test %0d: reset sweep %s", tests_run,
                 (error_count == errs_before) ? "ok" : "FAILED");
    endtask

    task automatic run_patterns();
        int      n;
        l2_rsp_t exp;
        n = 0;
        while (n < PAT_MAX && pat_mem[n*FIELDS] <= 32'(OP_INVAL)) begin
            if (n == 0 || pat_mem[n*FIELDS+6][0]) begin
                req_valid = 1'b0;
                wait_idle();
            end
            exp.op    = l2_op_e'(pat_mem[n*FIELDS][1:0]);
            exp.set   = pat_mem[n*FIELDS+1][SET_W-1:0];
            exp.tag   = pat_mem[n*FIELDS+2][TAG_W-1:0];
            exp.hit   = pat_mem[n*FIELDS+3][0];
            exp.way   = pat_mem[n*FIELDS+4][WAY_W-1:0];
            exp.evict = pat_mem[n*FIELDS+5][0];
            issue(exp);
            @(negedge clk);
            n++;
        end
        req_valid = 1'b0;
        wait_idle();
        if (n == 0) begin
            $display("The pattern file holds no commands");
            error_count++;
        end
    endtask

    // Six random tags into an empty set, then a lookup of each
    task automatic random_fill_test();
        logic [TAG_W-1:0] tags [6];
        logic [31:0]      rnd;
        l2_rsp_t          exp;
        m_valid = '0;
        m_rr    = '0;
        for (int i = 0; i < 6; i++) begin
            rnd     = $random(seed);
            tags[i] = {rnd[TAG_W-1:3], 3'(i)};
        end
        for (int pass = 0; pass < 2; pass++) begin
            for (int i = 0; i < 6; i++) begin
                predict((pass == 0) ? OP_FILL : OP_LOOKUP, 4'ha, tags[i], exp);
                wait_idle();
                issue(exp);
                @(negedge clk);
                req_valid = 1'b0;
            end
        end
        wait_idle();
    endtask

    initial begin
        seed      = 10644;
        reset     = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        // Unloaded entries keep an op value above every opcode
        for (int i = 0; i < PAT_MAX*FIELDS; i++) begin
            pat_mem[i] = 32'hffff_0000 | i;
        end
        $readmemh("verif/l2_tag_patterns.txt", pat_mem);
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        sweep_test();
        run_patterns();
        random_fill_test();
        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, error_count);
        if (error_count == 0 && tests_failed == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
